//--- compile.f
+incdir+include
source/lsp_lsf_pkg.sv
source/scratch_if.sv
source/scratch_mem.sv
source/cos_slope_rom.sv
source/lsf_interp.sv
source/lsf_convert.sv
source/lsp_lsf_pipe.sv
tests/tb_clock_gen.sv
tests/lsf_checker.sv
tests/tb_lsp_lsf_pipe.sv

//--- Bender.yml
package:
  name: lsp_lsf_pipe

export_include_dirs:
  - include

sources:
  - files:
      - source/lsp_lsf_pkg.sv
      - source/scratch_if.sv
      - source/scratch_mem.sv
      - source/cos_slope_rom.sv
      - source/lsf_interp.sv
      - source/lsf_convert.sv
      - source/lsp_lsf_pipe.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/lsf_checker.sv
      - tests/tb_lsp_lsf_pipe.sv

//--- cos_slope_table.mem
// Columns: cosine Q15 in bits 31:16, segment slope in bits 15:0
7fff9436
7fd9dd95
7f62eb35
7e9df11b
7d8af45d
7c2af674
7a7df7e0
7885f8ed
7642f9b8
73b6fa56
70e3fad6
6dcafb3d
6a6efb94
66d0fbdd
62f2fc1a
5ed7fc4e
5a82fc7b
55f6fca3
5134fcc5
4c40fce3
471dfcfc
41cefd12
3c57fd26
36bafd37
30fcfd45
2b1ffd51
2528fd5b
1f1afd64
18f9fd6a
12c8fd6f
0c8cfd72
0648fd74
0000fd74
f9b8fd72
f374fd6f
ed38fd6a
e707fd64
e0e6fd5b
dad8fd51
d4e1fd45
cf04fd37
c946fd26
c3a9fd12
be32fcfc
b8e3fce3
b3c0fcc5
aeccfca3
aa0afc7b
a57efc4e
a129fc1a
9d0efbdd
9930fb94
9592fb3d
9236fad6
8f1dfa56
8c4af9b8
89bef8ed
877bf7e0
8583f674
83d6f45d
8276f11b
8163eb35
809edd95
802796f9
80000000

//--- tests/tb_lsp_lsf_pipe.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

module tb_lsp_lsf_pipe
	import lsp_lsf_pkg::*;
();
	localparam int TEST_COUNT = 40;
	localparam int TEST_CYCLES = 300;

	logic                       clock;
	logic                       arst_n;
	logic                       start;
	logic                       test_mode;
	logic [`LSP_ADDR_WIDTH-1:0] lsf_addr;
	logic [`LSP_ADDR_WIDTH-1:0] test_write_addr;
	logic [`LSP_ADDR_WIDTH-1:0] test_read_addr;
	word32_t                    test_write;
	logic                       test_write_en;
	logic                       done;
	word32_t                    test_read_data;
	int                         value_errors;
	int                         control_errors;
	int                         conversions;
	int                         started;
	int                         run_errors;
	int                         cycles;
	int                         lsp_vec [`LSP_LPC_ORDER];
	int                         tmp;

	tb_clock_gen u_tb_clock_gen (.clock, .arst_n);

	lsp_lsf_pipe u_lsp_lsf_pipe (
		.clock, .arst_n, .start, .test_mode, .lsf_addr,
		.test_write_addr, .test_read_addr, .test_write, .test_write_en,
		.done, .test_read_data
	);

	lsf_checker u_lsf_checker (
		.clock, .arst_n, .start, .test_mode, .lsf_addr,
		.test_write_addr, .test_read_addr, .test_write, .test_write_en,
		.test_read_data, .done, .value_errors, .control_errors, .conversions
	);

	task automatic write_word(input int addr, input word32_t data);
		@(negedge clock);
		test_write_addr = `LSP_ADDR_WIDTH'(addr);
		test_write      = data;
		test_write_en   = 1'b1;
		@(negedge clock);
		test_write_en   = 1'b0;
	endtask

	// Checker compares the word one cycle later
	task automatic read_word(input int addr);
		@(negedge clock);
		test_read_addr = `LSP_ADDR_WIDTH'(addr);
	endtask

	task automatic convert_vector(input string name, input bit extra_start);
		int base;
		int waited;
		u_lsf_checker.test_name = name;
		base = 128 + ($urandom % 1800);
		for (int i = 0; i < `LSP_LPC_ORDER; i++)
			write_word(`LSP_BASE_ADDR + i,
				($urandom & 32'hffff_0000) | (lsp_vec[i] & 32'hffff));
		write_word(base - 1, $urandom);
		write_word(base + `LSP_LPC_ORDER, $urandom);
		@(negedge clock);
		test_mode = 1'b0;
		lsf_addr  = `LSP_ADDR_WIDTH'(base);
		start     = 1'b1;
		started++;
		@(negedge clock);
		start = 1'b0;
		if (extra_start)
		begin
			repeat (5) @(negedge clock);
			start = 1'b1;
			@(negedge clock);
			start = 1'b0;
		end
		waited = 0;
		while (!done && waited < TEST_CYCLES)
		begin
			@(negedge clock);
			waited++;
		end
		@(negedge clock);
		test_mode = 1'b1;
		// Results plus one canary on each side
		for (int a = base - 1; a <= base + `LSP_LPC_ORDER; a++)
			read_word(a);
		read_word(`LSP_BASE_ADDR);
		@(negedge clock);
	endtask

	task automatic sort_descending();
		for (int i = 0; i < `LSP_LPC_ORDER; i++)
			for (int j = 0; j < `LSP_LPC_ORDER - 1 - i; j++)
				if (lsp_vec[j] < lsp_vec[j + 1])
				begin
					tmp            = lsp_vec[j];
					lsp_vec[j]     = lsp_vec[j + 1];
					lsp_vec[j + 1] = tmp;
				end
	endtask

	task automatic random_vector();
		for (int i = 0; i < `LSP_LPC_ORDER; i++)
			lsp_vec[i] = int'($signed(16'($urandom)));
	endtask

	////////////////////
	// Stimulus

	initial
	begin
		int addrs [16];
		start           = 1'b0;
		test_mode       = 1'b1;
		lsf_addr        = '0;
		test_write_addr = '0;
		test_read_addr  = '0;
		test_write      = '0;
		test_write_en   = 1'b0;
		started = 0;
		run_errors = 0;
		void'($urandom(32'h45d7eb9b));
		@(posedge arst_n);
		u_lsf_checker.test_name = "test_port";
		for (int i = 0; i < 16; i++)
		begin
			addrs[i] = $urandom % (1 << `LSP_ADDR_WIDTH);
			write_word(addrs[i], $urandom);
		end
		for (int i = 0; i < 16; i++)
			read_word(addrs[i]);
		for (int t = 0; t < 30; t++)
		begin
			random_vector();
			sort_descending();
			convert_vector("random", 1'b0);
		end
		lsp_vec = '{32767, 32767, 23170, 23170, 0, -1608, -23170, -32729, -32768, -32768};
		convert_vector("edge_table", 1'b0);
		// Top value drives the index to 0, the rest then saturate
		lsp_vec = '{-32768, -32768, -32768, -32768, -32768,
			32767, 32767, 32767, 32767, 32767};
		convert_vector("edge_extreme", 1'b0);
		random_vector();
		convert_vector("unsorted", 1'b0);
		random_vector();
		sort_descending();
		convert_vector("second_start", 1'b1);
		repeat (4) @(negedge clock);
		if (conversions != started)
		begin
			run_errors++;
			$display("Conversion count mismatch: %0d started, %0d done", started, conversions);
		end
		$display("Errors: %0d value, %0d control, %0d run",
			value_errors, control_errors, run_errors);
		if (value_errors + control_errors + run_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Run bound from the test count and the cycles one test may take
	initial
	begin
		cycles = 0;
		while (cycles < TEST_COUNT * TEST_CYCLES)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("Run stopped after %0d cycles without finishing", cycles);
		$display("Errors: %0d value, %0d control, %0d run",
			value_errors, control_errors, run_errors);
		$display("*** FAILED ***");
		$finish;
	end
endmodule

//--- tests/lsf_checker.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

module lsf_checker
	import lsp_lsf_pkg::*;
(
	input  logic                       clock,
	input  logic                       arst_n,
	input  logic                       start,
	input  logic                       test_mode,
	input  logic [`LSP_ADDR_WIDTH-1:0] lsf_addr,
	input  logic [`LSP_ADDR_WIDTH-1:0] test_write_addr,
	input  logic [`LSP_ADDR_WIDTH-1:0] test_read_addr,
	input  word32_t                    test_write,
	input  logic                       test_write_en,
	input  word32_t                    test_read_data,
	input  logic                       done,
	output int                         value_errors,
	output int                         control_errors,
	output int                         conversions
);
	localparam int DEPTH = 1 << `LSP_ADDR_WIDTH;
	localparam int DONE_LIMIT = 300;

	logic [31:0] table_mem [`LSP_TABLE_LAST + 1];
	word32_t     shadow [DEPTH];
	bit          known [DEPTH];
	string       test_name;
	bit          busy;
	int          busy_cycles;
	bit          rd_pending;
	word32_t     rd_exp;
	int          rd_addr_q;

	initial
	begin
		$readmemh("cos_slope_table.mem", table_mem);
		test_name      = "reset";
		value_errors   = 0;
		control_errors = 0;
		conversions    = 0;
	end

	function automatic longint clip(input longint x, input longint lo, input longint hi);
		if (x > hi)
			return hi;
		if (x < lo)
			return lo;
		return x;
	endfunction

	////////////////////
	// Reference model

	// Sub, L_mult, L_shl by 3, round, then add of the segment offset
	function automatic int interp(input int lsp, input int c, input int s, input int idx);
		longint diff;
		longint prod;
		longint rnd;
		diff = clip(lsp - c, -32768, 32767);
		prod = clip(diff * s * 2, -64'sd2147483648, 64'sd2147483647);
		prod = clip(prod * 8, -64'sd2147483648, 64'sd2147483647);
		rnd  = clip(prod + 32768, -64'sd2147483648, 64'sd2147483647) >>> 16;
		return int'(clip(rnd + idx * 256, -32768, 32767));
	endfunction

	function automatic int cos_of(input int k);
		return int'($signed(table_mem[k][31:16]));
	endfunction

	function automatic void predict(input int base);
		int lsp [`LSP_LPC_ORDER];
		int idx;
		int res;
		int addr;
		for (int i = 0; i < `LSP_LPC_ORDER; i++)
			lsp[i] = int'($signed(shadow[`LSP_BASE_ADDR + i][15:0]));
		idx = `LSP_TABLE_LAST - 1;
		for (int i = `LSP_LPC_ORDER - 1; i >= 0; i--)
		begin
			while (idx > 0 && cos_of(idx) < lsp[i])
				idx--;
			res  = interp(lsp[i], cos_of(idx),
				int'($signed(table_mem[idx][15:0])), idx);
			addr = (base + i) % DEPTH;
			shadow[addr] = word32_t'(res);
			known[addr]  = 1'b1;
		end
	endfunction

	////////////////////
	// Port monitor

	always @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy       = 1'b0;
			rd_pending = 1'b0;
		end
		else
		begin
			// Read sees the word before a write on the same edge
			rd_pending = test_mode && known[test_read_addr];
			rd_exp     = shadow[test_read_addr];
			rd_addr_q  = test_read_addr;
			if (done)
			begin
				if (busy)
					conversions++;
				else
				begin
					control_errors++;
					$display("Test %s: done pulsed while no conversion was running",
						test_name);
				end
				busy = 1'b0;
			end
			if (busy)
			begin
				busy_cycles++;
				if (busy_cycles >= DONE_LIMIT)
				begin
					control_errors++;
					$display("Test %s: conversion never signalled done", test_name);
					busy = 1'b0;
				end
			end
			if (start && !busy)
			begin
				busy        = 1'b1;
				busy_cycles = 0;
				predict(int'(lsf_addr));
			end
			if (test_mode && test_write_en)
			begin
				shadow[test_write_addr] = test_write;
				known[test_write_addr]  = 1'b1;
			end
		end
	end

	// Registered read is stable by the falling edge
	always @(negedge clock)
	begin
		if (rd_pending && test_read_data !== rd_exp)
		begin
			value_errors++;
			$display("ERR %s addr %0h expected %08h actual %08h",
				test_name, rd_addr_q, rd_exp, test_read_data);
		end
	end
endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
(
	output logic clock,
	output logic arst_n
);
	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// Reset held for three cycles, released on a falling edge
	initial
	begin
		arst_n = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
	end
endmodule

//--- source/lsp_lsf_pipe.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

module lsp_lsf_pipe
	import lsp_lsf_pkg::*;
(
	input  logic                       clock,
	input  logic                       arst_n,
	input  logic                       start,
	input  logic                       test_mode,
	input  logic [`LSP_ADDR_WIDTH-1:0] lsf_addr,
	input  logic [`LSP_ADDR_WIDTH-1:0] test_write_addr,
	input  logic [`LSP_ADDR_WIDTH-1:0] test_read_addr,
	input  word32_t                    test_write,
	input  logic                       test_write_en,
	output logic                       done,
	output word32_t                    test_read_data
);
	logic [`LSP_ROM_ADDR_WIDTH-1:0] rom_addr;
	table_entry_t                   rom_entry;
	logic                           in_valid;
	word16_t                        lsp;
	word16_t                        cos;
	word16_t                        slope;
	logic [`LSP_ROM_ADDR_WIDTH-1:0] index;
	logic                           out_valid;
	word16_t                        lsf;

	scratch_if u_scratch_if ();

	////////////////////
	// Operand memories

	scratch_mem u_scratch_mem (
		.clock,
		.test_mode,
		.test_write_addr,
		.test_read_addr,
		.test_write,
		.test_write_en,
		.port           (u_scratch_if.mem),
		.test_read_data
	);

	cos_slope_rom u_cos_slope_rom (
		.clock,
		.rom_addr,
		.rom_entry
	);

	////////////////////
	// Control and datapath

	lsf_convert u_lsf_convert (
		.clock,
		.arst_n,
		.start,
		.lsf_addr,
		.mem       (u_scratch_if.ctrl),
		.rom_addr,
		.rom_entry,
		.in_valid,
		.lsp,
		.cos,
		.slope,
		.index,
		.out_valid,
		.lsf,
		.done
	);

	lsf_interp u_lsf_interp (
		.clock,
		.arst_n,
		.in_valid,
		.lsp,
		.cos,
		.slope,
		.index,
		.out_valid,
		.lsf
	);
endmodule

//--- source/lsf_convert.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

module lsf_convert
	import lsp_lsf_pkg::*;
(
	input  logic                           clock,
	input  logic                           arst_n,
	input  logic                           start,
	input  logic [`LSP_ADDR_WIDTH-1:0]     lsf_addr,
	scratch_if.ctrl                        mem,
	output logic [`LSP_ROM_ADDR_WIDTH-1:0] rom_addr,
	input  table_entry_t                   rom_entry,
	output logic                           in_valid,
	output word16_t                        lsp,
	output word16_t                        cos,
	output word16_t                        slope,
	output logic [`LSP_ROM_ADDR_WIDTH-1:0] index,
	input  logic                           out_valid,
	input  word16_t                        lsf,
	output logic                           done
);
	localparam int CNT_W = $clog2(`LSP_LPC_ORDER + 1);
	localparam logic [CNT_W-1:0] LAST_COEF = CNT_W'(`LSP_LPC_ORDER - 1);

	typedef enum logic [2:0] {IDLE, LOAD, SEARCH, ISSUE, DRAIN} state_t;

	state_t                         state;
	logic [CNT_W-1:0]               load_cnt;
	logic [CNT_W-1:0]               coef;
	logic [CNT_W-1:0]               res_cnt;
	logic [`LSP_ROM_ADDR_WIDTH-1:0] idx;
	logic [`LSP_ROM_ADDR_WIDTH-1:0] idx_next;
	word16_t                        lsp_regs [`LSP_LPC_ORDER];
	logic [`LSP_ADDR_WIDTH-1:0]     lsf_base;
	logic                           below;
	logic                           last_write;

	// Table entry still under the current LSP value
	assign below      = rom_entry.cos < lsp_regs[coef];
	assign last_write = out_valid && (res_cnt == '0);

	// ROM gets the next index so rom_entry tracks idx
	always_comb
	begin
		idx_next = idx;
		if (state == IDLE && start)
			idx_next = `LSP_ROM_ADDR_WIDTH'(`LSP_TABLE_LAST - 1);
		else if (state == SEARCH && below && idx != '0)
			idx_next = idx - 1'b1;
	end

	assign rom_addr = idx_next;

	////////////////////
	// Phase control

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= IDLE;
			load_cnt <= '0;
			coef     <= LAST_COEF;
			idx      <= `LSP_ROM_ADDR_WIDTH'(`LSP_TABLE_LAST - 1);
		end
		else
		begin
			idx <= idx_next;
			case (state)
				IDLE:
				begin
					load_cnt <= '0;
					if (start)
						state <= LOAD;
				end
				LOAD:
				begin
					load_cnt <= load_cnt + 1'b1;
					if (load_cnt == CNT_W'(`LSP_LPC_ORDER))
					begin
						state <= SEARCH;
						coef  <= LAST_COEF;
					end
				end
				SEARCH:
				begin
					if (!below || idx == '0)
						state <= ISSUE;
				end
				ISSUE:
				begin
					coef  <= coef - 1'b1;
					state <= (coef == '0) ? DRAIN : SEARCH;
				end
				DRAIN:
				begin
					if (last_write)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Results arrive for element 9 first
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			res_cnt <= LAST_COEF;
			done    <= 1'b0;
		end
		else
		begin
			done <= last_write;
			if (state == IDLE && start)
				res_cnt <= LAST_COEF;
			else if (out_valid)
				res_cnt <= res_cnt - 1'b1;
		end
	end

	// Read data lags the load address by one cycle
	always_ff @(posedge clock)
	begin
		if (state == IDLE && start)
			lsf_base <= lsf_addr;
		if (state == LOAD && load_cnt != '0)
			lsp_regs[load_cnt - 1'b1] <= mem.read_data[15:0];
	end

	////////////////////
	// Outputs

	assign in_valid = (state == ISSUE);
	assign lsp      = lsp_regs[coef];
	assign cos      = rom_entry.cos;
	assign slope    = rom_entry.slope;
	assign index    = idx;

	assign mem.read_addr  = `LSP_BASE_ADDR + `LSP_ADDR_WIDTH'(load_cnt);
	assign mem.write_en   = out_valid;
	assign mem.write_addr = lsf_base + `LSP_ADDR_WIDTH'(res_cnt);
	assign mem.write_data = word32_t'(lsf);
endmodule

//--- source/lsf_interp.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

module lsf_interp
	import lsp_lsf_pkg::*;
(
	input  logic                           clock,
	input  logic                           arst_n,
	input  logic                           in_valid,
	input  word16_t                        lsp,
	input  word16_t                        cos,
	input  word16_t                        slope,
	input  logic [`LSP_ROM_ADDR_WIDTH-1:0] index,
	output logic                           out_valid,
	output word16_t                        lsf
);
	localparam word32_t L_MAX = 32'h7fff_ffff;
	localparam word32_t L_MIN = 32'h8000_0000;

	////////////////////
	// Codec arithmetic

	// Clip a 17-bit result to 16 bits
	function automatic word16_t sat16(input logic signed [16:0] x);
		if (x > 17'sd32767)
			return 16'sh7fff;
		if (x < -17'sd32768)
			return 16'sh8000;
		return x[15:0];
	endfunction

	// Fractional product, only -1 * -1 overflows
	function automatic word32_t l_mult(input word16_t a, input word16_t b);
		word32_t p;
		p = a * b;
		if (p == 32'sh4000_0000)
			return L_MAX;
		return p <<< 1;
	endfunction

	function automatic word32_t l_shl3(input word32_t x);
		if (x > (L_MAX >>> 3))
			return L_MAX;
		if (x < (L_MIN >>> 3))
			return L_MIN;
		return x <<< 3;
	endfunction

	// Add half an LSB of the high word, keep the high word
	function automatic word16_t round16(input word32_t x);
		logic signed [32:0] s;
		s = 33'(x) + 33'sd32768;
		if (s > 33'(L_MAX))
			return 16'sh7fff;
		return s[31:16];
	endfunction

	////////////////////
	// Pipeline

	logic                           valid_1;
	word16_t                        diff;
	word32_t                        prod_q;
	logic [`LSP_ROM_ADDR_WIDTH-1:0] index_q;
	word16_t                        rounded;
	word16_t                        index_shl;

	assign diff      = sat16(17'(lsp) - 17'(cos));
	assign rounded   = round16(l_shl3(prod_q));
	assign index_shl = word16_t'(index_q) <<< 8;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_1   <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			valid_1   <= in_valid;
			out_valid <= valid_1;
		end
	end

	// Stage 1 product, stage 2 scaled result plus segment offset
	always_ff @(posedge clock)
	begin
		prod_q  <= l_mult(diff, slope);
		index_q <= index;
		lsf     <= sat16(17'(rounded) + 17'(index_shl));
	end
endmodule

//--- source/cos_slope_rom.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

module cos_slope_rom
	import lsp_lsf_pkg::*;
(
	input  logic                           clock,
	input  logic [`LSP_ROM_ADDR_WIDTH-1:0] rom_addr,
	output table_entry_t                   rom_entry
);
	// Cosine in bits 31:16, slope in bits 15:0
	logic [31:0] table_mem [`LSP_TABLE_LAST + 1];

	initial
	begin
		$readmemh("cos_slope_table.mem", table_mem);
	end

	always_ff @(posedge clock)
	begin
		rom_entry <= table_entry_t'(table_mem[rom_addr]);
	end
endmodule

//--- source/scratch_mem.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

module scratch_mem
	import lsp_lsf_pkg::*;
(
	input  logic                       clock,
	input  logic                       test_mode,
	input  logic [`LSP_ADDR_WIDTH-1:0] test_write_addr,
	input  logic [`LSP_ADDR_WIDTH-1:0] test_read_addr,
	input  word32_t                    test_write,
	input  logic                       test_write_en,
	scratch_if.mem                     port,
	output word32_t                    test_read_data
);
	localparam int DEPTH = 1 << `LSP_ADDR_WIDTH;

	word32_t                    ram [DEPTH];
	logic [`LSP_ADDR_WIDTH-1:0] wr_addr;
	logic [`LSP_ADDR_WIDTH-1:0] rd_addr;
	word32_t                    wr_data;
	logic                       wr_en;
	word32_t                    rd_q;

	// Test port takes both ports while test_mode is high
	always_comb
	begin
		if (test_mode)
		begin
			wr_addr = test_write_addr;
			wr_data = test_write;
			wr_en   = test_write_en;
			rd_addr = test_read_addr;
		end
		else
		begin
			wr_addr = port.write_addr;
			wr_data = port.write_data;
			wr_en   = port.write_en;
			rd_addr = port.read_addr;
		end
	end

	always_ff @(posedge clock)
	begin
		if (wr_en)
			ram[wr_addr] <= wr_data;
		rd_q <= ram[rd_addr];
	end

	// Same registered word feeds the controller and the test port
	assign port.read_data = rd_q;
	assign test_read_data = rd_q;
endmodule

//--- source/scratch_if.sv
`timescale 1ns/1ns
`include "lsp_lsf_settings.svh"

interface scratch_if
	import lsp_lsf_pkg::*;
();
	logic [`LSP_ADDR_WIDTH-1:0] read_addr;
	logic [`LSP_ADDR_WIDTH-1:0] write_addr;
	word32_t                    write_data;
	logic                       write_en;
	word32_t                    read_data;

	// Controller side
	modport ctrl (
		output read_addr, write_addr, write_data, write_en,
		input  read_data
	);

	// Memory side
	modport mem (
		input  read_addr, write_addr, write_data, write_en,
		output read_data
	);
endinterface

//--- source/lsp_lsf_pkg.sv
package lsp_lsf_pkg;

	// Codec word types
	typedef logic signed [15:0] word16_t;
	typedef logic signed [31:0] word32_t;

	// One table word, cosine in the upper half
	typedef struct packed
	{
		word16_t cos;
		word16_t slope;
	} table_entry_t;

endpackage

//--- include/lsp_lsf_settings.svh
`ifndef LSP_LSF_SETTINGS_SVH
`define LSP_LSF_SETTINGS_SVH

// Number of LPC coefficients per frame
`define LSP_LPC_ORDER 10

// Highest cosine table index, search starts one below
`define LSP_TABLE_LAST 64

// Scratch and table address widths
`define LSP_ADDR_WIDTH 11
`define LSP_ROM_ADDR_WIDTH 7

// Scratch location of LSP element 0
`define LSP_BASE_ADDR 11'd64

`endif
